// File: hdl/noncomp_pkg.sv
// --------------------------------------------------
// Shared definitions for the non-computational slice
// Widths, formats, operation codes, status flags,
// lane side data and the FP32/FP16 operand word
// --------------------------------------------------

package noncomp_pkg;

  // --------------------------------------------------
  // Datapath geometry
  // --------------------------------------------------
  localparam int unsigned DATA_W        = 32;
  localparam int unsigned LANE_W        = 32;
  localparam int unsigned FP16_W        = 16;
  localparam int unsigned NUM_LANES     = 2;
  localparam int unsigned NUM_PIPE_REGS = 2;
  localparam int unsigned TAG_W         = 4;

  // Canonical quiet NaNs
  localparam logic [DATA_W-1:0] CNAN_FP32 = 32'h7fc0_0000;
  localparam logic [FP16_W-1:0] CNAN_FP16 = 16'h7e00;

  // --------------------------------------------------
  // Encodings
  // --------------------------------------------------
  typedef enum logic {
    FMT_FP32 = 1'b0,
    FMT_FP16 = 1'b1
  } fp_fmt_e;

  typedef enum logic [2:0] {
    OP_MIN   = 3'd0,
    OP_MAX   = 3'd1,
    OP_SGNJ  = 3'd2,
    OP_SGNJN = 3'd3,
    OP_SGNJX = 3'd4
  } noncomp_op_e;

  // IEEE exception flags, only nv is raised by this unit
  typedef struct packed {
    logic nv;
    logic dz;
    logic of;
    logic uf;
    logic nx;
  } status_t;

  // Side data carried along with lane 0
  typedef struct packed {
    logic    vectorial;
    fp_fmt_e fmt;
  } lane_aux_t;

  // One operand word, seen as a single FP32 value or two FP16 values
  typedef union packed {
    logic [DATA_W-1:0]            fp32;
    logic [1:0][FP16_W-1:0]       fp16;
  } fp_word_u;

endpackage

// File: hdl/lane_result_if.sv
// --------------------------------------------------
// Result bundle of one lane towards the packer
// --------------------------------------------------

`timescale 1ns/1ps

interface lane_result_if;

  logic [noncomp_pkg::LANE_W-1:0] result;
  noncomp_pkg::status_t           status;
  logic                           mask;
  logic                           valid;
  logic                           busy;
  logic                           ready;

  // Lane side produces the bundle, packer returns ready
  modport lane (
    output result,
    output status,
    output mask,
    output valid,
    output busy,
    input  ready
  );

  modport packer (
    input  result,
    input  status,
    input  mask,
    input  valid,
    input  busy,
    output ready
  );

endinterface

// File: hdl/operand_slicer.sv
// --------------------------------------------------
// Operand slicer
// Splits both operands into lane-local words and
// raises the upper lane valid for FP16 vectors only
// --------------------------------------------------

`timescale 1ns/1ps

module operand_slicer (
  input  noncomp_pkg::fp_word_u op_a_i,
  input  noncomp_pkg::fp_word_u op_b_i,
  input  noncomp_pkg::fp_fmt_e  fmt_i,
  input  logic                  vectorial_i,
  input  logic                  in_valid_i,
  output logic [noncomp_pkg::NUM_LANES-1:0][noncomp_pkg::LANE_W-1:0] lane_a_o,
  output logic [noncomp_pkg::NUM_LANES-1:0][noncomp_pkg::LANE_W-1:0] lane_b_o,
  output logic [noncomp_pkg::NUM_LANES-1:0]                          lane_valid_o
);

  logic vec_fp16;

  // Only FP16 packs two values into one word
  assign vec_fp16 = vectorial_i & (fmt_i == noncomp_pkg::FMT_FP16);

  // --------------------------------------------------
  // Lane 0 sees the whole low word
  // --------------------------------------------------
  // The lane decodes FP32 or the low FP16 half itself
  assign lane_a_o[0] = op_a_i.fp32;
  assign lane_b_o[0] = op_b_i.fp32;

  // --------------------------------------------------
  // Lane 1 gets the upper FP16 half
  // --------------------------------------------------
  always_comb begin : slice_upper
    lane_a_o[1] = '0;
    lane_b_o[1] = '0;
    if (vec_fp16) begin
      lane_a_o[1][noncomp_pkg::FP16_W-1:0] = op_a_i.fp16[1];
      lane_b_o[1][noncomp_pkg::FP16_W-1:0] = op_b_i.fp16[1];
    end
  end

  // Upper lane only carries vectorial operations
  assign lane_valid_o[0] = in_valid_i;
  assign lane_valid_o[1] = in_valid_i & vec_fp16;

endmodule

// File: hdl/noncomp_lane.sv
// --------------------------------------------------
// One SIMD lane
// Min, max and sign injection on FP32 or FP16,
// followed by valid/ready register stages
// --------------------------------------------------

`timescale 1ns/1ps

module noncomp_lane #(
  parameter int unsigned LaneIdx = 0
) (
  input  logic                                  clk_i,
  input  logic                                  arst_n_i,
  input  logic [noncomp_pkg::LANE_W-1:0]        a_i,
  input  logic [noncomp_pkg::LANE_W-1:0]        b_i,
  input  noncomp_pkg::noncomp_op_e              op_i,
  input  noncomp_pkg::fp_fmt_e                  fmt_i,
  input  logic                                  mask_i,
  input  noncomp_pkg::lane_aux_t                aux_i,
  input  logic [noncomp_pkg::TAG_W-1:0]         tag_i,
  input  logic                                  in_valid_i,
  output logic                                  in_ready_o,
  output noncomp_pkg::lane_aux_t                aux_o,
  output logic [noncomp_pkg::TAG_W-1:0]         tag_o,
  lane_result_if.lane                           res_if
);

  logic                           is_fp32;
  logic                           sign_a, sign_b;
  logic [30:0]                    mag_a, mag_b;
  logic                           nan_a, nan_b;
  logic                           snan_a, snan_b;
  logic                           a_lt_b;
  logic                           new_sign;
  logic                           use_mm;
  logic [noncomp_pkg::LANE_W-1:0] cnan;
  logic [noncomp_pkg::LANE_W-1:0] mm_sel;
  logic [noncomp_pkg::LANE_W-1:0] mm_fit;
  logic [noncomp_pkg::LANE_W-1:0] injected;
  logic [noncomp_pkg::LANE_W-1:0] op_result;
  noncomp_pkg::status_t           op_status;

  // Upper lane never sees FP32, so its FP32 path folds away
  assign is_fp32 = (LaneIdx == 0) ? (fmt_i == noncomp_pkg::FMT_FP32) : 1'b0;
  assign cnan    = is_fp32 ? noncomp_pkg::CNAN_FP32 : {16'b0, noncomp_pkg::CNAN_FP16};

  // Sign, magnitude and NaN class of each operand in the active format
  always_comb begin : decode
    if (is_fp32) begin
      sign_a = a_i[31];
      mag_a  = a_i[30:0];
      nan_a  = (&a_i[30:23]) & (|a_i[22:0]);
      snan_a = nan_a & ~a_i[22];
      sign_b = b_i[31];
      mag_b  = b_i[30:0];
      nan_b  = (&b_i[30:23]) & (|b_i[22:0]);
      snan_b = nan_b & ~b_i[22];
    end else begin
      sign_a = a_i[15];
      mag_a  = {16'b0, a_i[14:0]};
      nan_a  = (&a_i[14:10]) & (|a_i[9:0]);
      snan_a = nan_a & ~a_i[9];
      sign_b = b_i[15];
      mag_b  = {16'b0, b_i[14:0]};
      nan_b  = (&b_i[14:10]) & (|b_i[9:0]);
      snan_b = nan_b & ~b_i[9];
    end
  end

  // --------------------------------------------------
  // Min / max
  // --------------------------------------------------
  always_comb begin : minmax
    // Differing signs: the negative one is smaller, so -0 < +0
    if (sign_a != sign_b) begin
      a_lt_b = sign_a;
    end else if (sign_a) begin
      a_lt_b = mag_a > mag_b;
    end else begin
      a_lt_b = mag_a < mag_b;
    end

    if (nan_a & nan_b) begin
      mm_sel = cnan;
    end else if (nan_a) begin
      mm_sel = b_i;
    end else if (nan_b) begin
      mm_sel = a_i;
    end else if (op_i == noncomp_pkg::OP_MIN) begin
      mm_sel = a_lt_b ? a_i : b_i;
    end else begin
      mm_sel = a_lt_b ? b_i : a_i;
    end
    mm_fit = is_fp32 ? mm_sel : {16'b0, mm_sel[15:0]};
  end

  // --------------------------------------------------
  // Operation select and sign injection
  // --------------------------------------------------
  always_comb begin : compute
    op_status = '0;
    new_sign  = sign_a;
    use_mm    = 1'b0;
    case (op_i)
      noncomp_pkg::OP_MIN,
      noncomp_pkg::OP_MAX: begin
        use_mm       = 1'b1;
        op_status.nv = snan_a | snan_b;
      end
      noncomp_pkg::OP_SGNJ:  new_sign = sign_b;
      noncomp_pkg::OP_SGNJN: new_sign = ~sign_b;
      noncomp_pkg::OP_SGNJX: new_sign = sign_a ^ sign_b;
      default:               new_sign = sign_a;
    endcase
    injected  = is_fp32 ? {new_sign, a_i[30:0]} : {16'b0, new_sign, a_i[14:0]};
    op_result = use_mm ? mm_fit : injected;
  end

  // --------------------------------------------------
  // Pipeline, index i holds the item after i stages
  // --------------------------------------------------
  logic                           pipe_valid  [0:noncomp_pkg::NUM_PIPE_REGS];
  logic                           pipe_ready  [0:noncomp_pkg::NUM_PIPE_REGS];
  logic [noncomp_pkg::LANE_W-1:0] pipe_result [0:noncomp_pkg::NUM_PIPE_REGS];
  noncomp_pkg::status_t           pipe_status [0:noncomp_pkg::NUM_PIPE_REGS];
  logic                           pipe_mask   [0:noncomp_pkg::NUM_PIPE_REGS];
  noncomp_pkg::lane_aux_t         pipe_aux    [0:noncomp_pkg::NUM_PIPE_REGS];
  logic [noncomp_pkg::TAG_W-1:0]  pipe_tag    [0:noncomp_pkg::NUM_PIPE_REGS];

  assign pipe_valid[0]  = in_valid_i;
  assign pipe_result[0] = op_result;
  assign pipe_status[0] = op_status;
  assign pipe_mask[0]   = mask_i;
  assign pipe_aux[0]    = aux_i;
  assign pipe_tag[0]    = tag_i;

  for (genvar i = 0; i < noncomp_pkg::NUM_PIPE_REGS; i++) begin : gen_stage
    logic reg_en;

    // Advance when the next stage moves on or holds a bubble
    assign pipe_ready[i] = pipe_ready[i+1] | ~pipe_valid[i+1];
    assign reg_en        = pipe_ready[i] & pipe_valid[i];

    always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
        pipe_valid[i+1] <= 1'b0;
      end else if (pipe_ready[i]) begin
        pipe_valid[i+1] <= pipe_valid[i];
      end
    end

    always_ff @(posedge clk_i) begin
      if (reg_en) begin
        pipe_result[i+1] <= pipe_result[i];
        pipe_status[i+1] <= pipe_status[i];
        pipe_mask[i+1]   <= pipe_mask[i];
        pipe_aux[i+1]    <= pipe_aux[i];
        pipe_tag[i+1]    <= pipe_tag[i];
      end
    end
  end

  // Output side, ready comes back from the packer
  assign pipe_ready[noncomp_pkg::NUM_PIPE_REGS] = res_if.ready;
  assign in_ready_o    = pipe_ready[0];
  assign res_if.valid  = pipe_valid[noncomp_pkg::NUM_PIPE_REGS];
  assign res_if.result = pipe_result[noncomp_pkg::NUM_PIPE_REGS];
  assign res_if.status = pipe_status[noncomp_pkg::NUM_PIPE_REGS];
  assign res_if.mask   = pipe_mask[noncomp_pkg::NUM_PIPE_REGS];
  assign aux_o         = pipe_aux[noncomp_pkg::NUM_PIPE_REGS];
  assign tag_o         = pipe_tag[noncomp_pkg::NUM_PIPE_REGS];

  always_comb begin : busy_or
    res_if.busy = 1'b0;
    for (int i = 0; i <= noncomp_pkg::NUM_PIPE_REGS; i++) begin
      res_if.busy |= pipe_valid[i];
    end
  end

endmodule

// File: hdl/result_packer.sv
// --------------------------------------------------
// Result packer
// Packs lane results by format with NaN-boxing,
// collapses status flags and drives lane readies
// --------------------------------------------------

`timescale 1ns/1ps

module result_packer (
  lane_result_if.packer                  lane0_if,
  lane_result_if.packer                  lane1_if,
  input  noncomp_pkg::lane_aux_t         aux_i,
  input  logic                           out_ready_i,
  output logic [noncomp_pkg::DATA_W-1:0] result_o,
  output noncomp_pkg::status_t           status_o,
  output logic                           out_valid_o,
  output logic                           busy_o
);

  logic                  vec_result;
  noncomp_pkg::fp_word_u packed_word;
  noncomp_pkg::status_t  lane0_status;
  noncomp_pkg::status_t  lane1_status;

  // Upper lane is only in use for FP16 vectors
  assign vec_result = aux_i.vectorial & (aux_i.fmt == noncomp_pkg::FMT_FP16);

  // --------------------------------------------------
  // Handshake
  // --------------------------------------------------
  // Lane 1 pops together with the lane-0 vector item it belongs to
  assign lane0_if.ready = out_ready_i;
  assign lane1_if.ready = out_ready_i & vec_result;
  assign out_valid_o    = lane0_if.valid;
  assign busy_o         = lane0_if.busy | lane1_if.busy;

  // --------------------------------------------------
  // Result assembly
  // --------------------------------------------------
  always_comb begin : pack
    packed_word.fp32 = lane0_if.result;
    if (aux_i.fmt == noncomp_pkg::FMT_FP16) begin
      if (vec_result) begin
        packed_word.fp16[1] = lane1_if.result[noncomp_pkg::FP16_W-1:0];
      end else begin
        // Scalar FP16 is NaN-boxed
        packed_word.fp16[1] = '1;
      end
    end
  end

  assign result_o = packed_word.fp32;

  // --------------------------------------------------
  // Status collapse under the SIMD mask
  // --------------------------------------------------
  assign lane0_status = lane0_if.status & {5{lane0_if.mask}};
  assign lane1_status = lane1_if.status
                        & {5{lane1_if.mask & lane1_if.valid & vec_result}};
  assign status_o     = lane0_status | lane1_status;

endmodule

// File: hdl/noncomp_slice.sv
// --------------------------------------------------
// Two-lane SIMD slice for min, max and sign injection
// Top level with slicer, two lanes and result packer
// --------------------------------------------------

`timescale 1ns/1ps

module noncomp_slice (
  input  logic                                clk_i,
  input  logic                                arst_n_i,
  input  logic [noncomp_pkg::DATA_W-1:0]      op_a_i,
  input  logic [noncomp_pkg::DATA_W-1:0]      op_b_i,
  input  noncomp_pkg::noncomp_op_e            op_i,
  input  noncomp_pkg::fp_fmt_e                fmt_i,
  input  logic                                vectorial_i,
  input  logic [noncomp_pkg::NUM_LANES-1:0]   simd_mask_i,
  input  logic [noncomp_pkg::TAG_W-1:0]       tag_i,
  input  logic                                in_valid_i,
  output logic                                in_ready_o,
  output logic [noncomp_pkg::DATA_W-1:0]      result_o,
  output noncomp_pkg::status_t                status_o,
  output logic [noncomp_pkg::TAG_W-1:0]       tag_o,
  output logic                                out_valid_o,
  input  logic                                out_ready_i,
  output logic                                busy_o
);

  logic [noncomp_pkg::NUM_LANES-1:0][noncomp_pkg::LANE_W-1:0] lane_a;
  logic [noncomp_pkg::NUM_LANES-1:0][noncomp_pkg::LANE_W-1:0] lane_b;
  logic [noncomp_pkg::NUM_LANES-1:0]                          lane_valid;
  noncomp_pkg::lane_aux_t                                     in_aux;
  noncomp_pkg::lane_aux_t                                     out_aux;

  lane_result_if i_lane0_if ();
  lane_result_if i_lane1_if ();

  assign in_aux = noncomp_pkg::lane_aux_t'({vectorial_i, fmt_i});

  // Lane valids only pass when lane 0 takes the item, keeping lanes in step
  operand_slicer i_operand_slicer (
    .op_a_i       ( op_a_i                  ),
    .op_b_i       ( op_b_i                  ),
    .fmt_i        ( fmt_i                   ),
    .vectorial_i  ( vectorial_i             ),
    .in_valid_i   ( in_valid_i & in_ready_o ),
    .lane_a_o     ( lane_a                  ),
    .lane_b_o     ( lane_b                  ),
    .lane_valid_o ( lane_valid              )
  );

  noncomp_lane #(.LaneIdx(0)) i_lane0 (
    .clk_i, .arst_n_i,
    .a_i(lane_a[0]), .b_i(lane_b[0]), .op_i, .fmt_i,
    .mask_i(simd_mask_i[0]), .aux_i(in_aux), .tag_i,
    .in_valid_i(lane_valid[0]), .in_ready_o,
    .aux_o(out_aux), .tag_o, .res_if(i_lane0_if)
  );

  // Side data and upstream ready of lane 1 are not needed
  noncomp_lane #(.LaneIdx(1)) i_lane1 (
    .clk_i, .arst_n_i,
    .a_i(lane_a[1]), .b_i(lane_b[1]), .op_i, .fmt_i,
    .mask_i(simd_mask_i[1]), .aux_i(in_aux), .tag_i,
    .in_valid_i(lane_valid[1]), .in_ready_o(),
    .aux_o(), .tag_o(), .res_if(i_lane1_if)
  );

  result_packer i_result_packer (
    .lane0_if    ( i_lane0_if  ),
    .lane1_if    ( i_lane1_if  ),
    .aux_i       ( out_aux     ),
    .out_ready_i ( out_ready_i ),
    .result_o    ( result_o    ),
    .status_o    ( status_o    ),
    .out_valid_o ( out_valid_o ),
    .busy_o      ( busy_o      )
  );

endmodule

// File: tests/tb_clock_gen.sv
// --------------------------------------------------
// Testbench clock and reset source
// 100 ns clock, reset held low for 16 cycles
// --------------------------------------------------

`timescale 1ns/1ps

module tb_clock_gen (
  output logic clk_o,
  output logic arst_n_o
);

  localparam int HALF_PERIOD_NS = 50;
  localparam int RESET_CYCLES   = 16;

  initial begin
    clk_o    = 1'b0;
    arst_n_o = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    #1 arst_n_o = 1'b1;
  end

  always #HALF_PERIOD_NS clk_o = ~clk_o;

endmodule

// File: tests/tb_model.svh
// --------------------------------------------------
// Reference model for min, max and sign injection
// FP16 and FP32 lane functions, full item packing
// --------------------------------------------------

`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

// Result in the low bits, nv flag on top
function automatic logic [16:0] model_fp16(input logic [15:0] a, input logic [15:0] b,
                                           input noncomp_pkg::noncomp_op_e op);
  logic        nan_a;
  logic        nan_b;
  logic        snan;
  logic        a_lt_b;
  logic [15:0] res;
  nan_a  = (a[14:10] == 5'h1f) && (a[9:0] != 10'h0);
  nan_b  = (b[14:10] == 5'h1f) && (b[9:0] != 10'h0);
  snan   = (nan_a && !a[9]) || (nan_b && !b[9]);
  // Ordering on sign and magnitude puts -0 below +0
  if (a[15] != b[15]) a_lt_b = a[15];
  else if (a[15]) a_lt_b = a[14:0] > b[14:0];
  else a_lt_b = a[14:0] < b[14:0];
  case (op)
    noncomp_pkg::OP_SGNJ:  return {1'b0, b[15], a[14:0]};
    noncomp_pkg::OP_SGNJN: return {1'b0, ~b[15], a[14:0]};
    noncomp_pkg::OP_SGNJX: return {1'b0, a[15] ^ b[15], a[14:0]};
    default: begin
      if (nan_a && nan_b) res = noncomp_pkg::CNAN_FP16;
      else if (nan_a) res = b;
      else if (nan_b) res = a;
      else if (op == noncomp_pkg::OP_MIN) res = a_lt_b ? a : b;
      else res = a_lt_b ? b : a;
      return {snan, res};
    end
  endcase
endfunction

function automatic logic [32:0] model_fp32(input logic [31:0] a, input logic [31:0] b,
                                           input noncomp_pkg::noncomp_op_e op);
  logic        nan_a;
  logic        nan_b;
  logic        snan;
  logic        a_lt_b;
  logic [31:0] res;
  nan_a  = (a[30:23] == 8'hff) && (a[22:0] != 23'h0);
  nan_b  = (b[30:23] == 8'hff) && (b[22:0] != 23'h0);
  snan   = (nan_a && !a[22]) || (nan_b && !b[22]);
  if (a[31] != b[31]) a_lt_b = a[31];
  else if (a[31]) a_lt_b = a[30:0] > b[30:0];
  else a_lt_b = a[30:0] < b[30:0];
  case (op)
    noncomp_pkg::OP_SGNJ:  return {1'b0, b[31], a[30:0]};
    noncomp_pkg::OP_SGNJN: return {1'b0, ~b[31], a[30:0]};
    noncomp_pkg::OP_SGNJX: return {1'b0, a[31] ^ b[31], a[30:0]};
    default: begin
      if (nan_a && nan_b) res = noncomp_pkg::CNAN_FP32;
      else if (nan_a) res = b;
      else if (nan_b) res = a;
      else if (op == noncomp_pkg::OP_MIN) res = a_lt_b ? a : b;
      else res = a_lt_b ? b : a;
      return {snan, res};
    end
  endcase
endfunction

// Whole output word and status for one item
function automatic void model_item(input noncomp_pkg::fp_word_u a,
                                   input noncomp_pkg::fp_word_u b,
                                   input noncomp_pkg::noncomp_op_e op,
                                   input noncomp_pkg::fp_fmt_e fmt, input logic vec,
                                   input logic [1:0] mask,
                                   output logic [31:0] res, output noncomp_pkg::status_t st);
  logic [32:0]           r32;
  logic [16:0]           r_lo;
  logic [16:0]           r_hi;
  noncomp_pkg::fp_word_u w;
  st = '0;
  if (fmt == noncomp_pkg::FMT_FP32) begin
    r32    = model_fp32(a.fp32, b.fp32, op);
    w.fp32 = r32[31:0];
    st.nv  = r32[32] & mask[0];
  end else begin
    r_lo       = model_fp16(a.fp16[0], b.fp16[0], op);
    w.fp16[0]  = r_lo[15:0];
    // Scalar FP16 results are NaN-boxed
    w.fp16[1]  = 16'hffff;
    st.nv      = r_lo[16] & mask[0];
    if (vec) begin
      r_hi      = model_fp16(a.fp16[1], b.fp16[1], op);
      w.fp16[1] = r_hi[15:0];
      st.nv     = st.nv | (r_hi[16] & mask[1]);
    end
  end
  res = w.fp32;
endfunction

`endif

// File: tests/tb_noncomp_slice.sv
// --------------------------------------------------
// Testbench for the two-lane noncomp slice
// Random stimulus, scoreboard queues, compare tasks,
// watchdog and closing summary
// --------------------------------------------------

`timescale 1ns/1ps

module tb_noncomp_slice;

  localparam int CLK_PERIOD_NS  = 100;
  localparam int ITEMS_PER_TEST = 60;
  localparam int STALL_ITEMS    = 200;
  localparam int TOTAL_ITEMS    = 4 * ITEMS_PER_TEST + STALL_ITEMS;

  logic                               clk, arst_n;
  logic [noncomp_pkg::DATA_W-1:0]     op_a, op_b, result;
  noncomp_pkg::noncomp_op_e           op;
  noncomp_pkg::fp_fmt_e               fmt;
  logic                               vectorial, in_valid, in_ready;
  logic                               out_valid, out_ready, busy, stall_en;
  logic [noncomp_pkg::NUM_LANES-1:0]  simd_mask;
  logic [noncomp_pkg::TAG_W-1:0]      tag_in, tag_out, next_tag;
  noncomp_pkg::status_t               status;

  // Scoreboard filled on accept and emptied on leave
  logic [noncomp_pkg::DATA_W-1:0]     exp_res[$];
  noncomp_pkg::status_t               exp_st[$];
  logic [noncomp_pkg::TAG_W-1:0]      exp_tag[$];
  int                                 errors, items_checked, tests_run;

  `include "tb_model.svh"

  tb_clock_gen i_tb_clock_gen (.clk_o(clk), .arst_n_o(arst_n));

  noncomp_slice i_noncomp_slice (
    .clk_i(clk), .arst_n_i(arst_n), .op_a_i(op_a), .op_b_i(op_b), .op_i(op),
    .fmt_i(fmt), .vectorial_i(vectorial), .simd_mask_i(simd_mask), .tag_i(tag_in),
    .in_valid_i(in_valid), .in_ready_o(in_ready), .result_o(result), .status_o(status),
    .tag_o(tag_out), .out_valid_o(out_valid), .out_ready_i(out_ready), .busy_o(busy)
  );

  // --------------------------------------------------
  // Compare tasks
  // --------------------------------------------------
  task automatic check_result(input logic [noncomp_pkg::DATA_W-1:0] got,
                              input logic [noncomp_pkg::DATA_W-1:0] exp, input string what);
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED at %0t: %s got %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_status(input noncomp_pkg::status_t got,
                              input noncomp_pkg::status_t exp, input string what);
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED at %0t: %s got %b, expected %b", $time, what, got, exp);
    end
  endtask

  task automatic check_tag(input logic [noncomp_pkg::TAG_W-1:0] got,
                           input logic [noncomp_pkg::TAG_W-1:0] exp, input string what);
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED at %0t: %s got %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_flag(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED at %0t: %s got %b, expected %b", $time, what, got, exp);
    end
  endtask

  // --------------------------------------------------
  // Stimulus helpers
  // --------------------------------------------------
  // About a quarter are quiet NaN, signaling NaN or signed zero
  function automatic logic [15:0] rand_fp16();
    logic [31:0] r;
    r = $urandom;
    case ($urandom_range(11))
      0:       return {r[15], 5'h1f, 1'b1, r[8:0]};
      1:       return {r[15], 5'h1f, 1'b0, r[8:1], 1'b1};
      2:       return {r[15], 15'h0};
      default: return r[15:0];
    endcase
  endfunction

  function automatic logic [31:0] rand_fp32();
    logic [31:0] r;
    r = $urandom;
    case ($urandom_range(11))
      0:       return {r[31], 8'hff, 1'b1, r[21:0]};
      1:       return {r[31], 8'hff, 1'b0, r[21:1], 1'b1};
      2:       return {r[31], 31'h0};
      default: return r;
    endcase
  endfunction

  function automatic logic [31:0] rand_word(input noncomp_pkg::fp_fmt_e f);
    if (f == noncomp_pkg::FMT_FP32) return rand_fp32();
    return {rand_fp16(), rand_fp16()};
  endfunction

  // Ends 1 ns after the rising edge and redraws output ready
  task automatic next_cycle();
    @(posedge clk);
    #1;
    out_ready = stall_en ? ($urandom_range(3) != 0) : 1'b1;
  endtask

  task automatic send_item(input logic [31:0] a, input logic [31:0] b,
                           input noncomp_pkg::noncomp_op_e o,
                           input noncomp_pkg::fp_fmt_e f, input logic v);
    logic [31:0]          er;
    noncomp_pkg::status_t es;
    logic                 accepted;
    op_a      = a;
    op_b      = b;
    op        = o;
    fmt       = f;
    vectorial = v;
    simd_mask = 2'($urandom_range(3));
    tag_in    = next_tag;
    in_valid  = 1'b1;
    model_item(a, b, o, f, v, simd_mask, er, es);
    accepted = 1'b0;
    while (!accepted) begin
      @(negedge clk);
      accepted = in_ready;
      if (accepted) begin
        exp_res.push_back(er);
        exp_st.push_back(es);
        exp_tag.push_back(next_tag);
      end
      next_cycle();
    end
    next_tag = next_tag + 1'b1;
  endtask

  task automatic drain();
    in_valid = 1'b0;
    while (exp_res.size() != 0) next_cycle();
    check_flag(busy, 1'b0, "busy_o after drain");
  endtask

  // Mode 0 FP32 min/max, 1 FP16 scalar, 2 FP16 vector, 3 sign injection, 4 mixed
  task automatic run_items(input string name, input int n, input int mode);
    noncomp_pkg::noncomp_op_e o;
    noncomp_pkg::fp_fmt_e     f;
    logic                     v;
    logic [31:0]              a;
    logic [31:0]              b;
    logic [31:0]              sign_bits;
    int                       errors_before;
    errors_before = errors;
    for (int i = 0; i < n; i++) begin
      f = noncomp_pkg::fp_fmt_e'(1'($urandom_range(1)));
      v = (f == noncomp_pkg::FMT_FP16) ? 1'($urandom_range(1)) : 1'b0;
      o = noncomp_pkg::noncomp_op_e'(3'($urandom_range(4)));
      case (mode)
        0: begin
          f = noncomp_pkg::FMT_FP32;
          v = 1'b0;
          o = ($urandom_range(1) != 0) ? noncomp_pkg::OP_MAX : noncomp_pkg::OP_MIN;
        end
        1: begin
          f = noncomp_pkg::FMT_FP16;
          v = 1'b0;
        end
        2: begin
          f = noncomp_pkg::FMT_FP16;
          v = 1'b1;
        end
        3: o = noncomp_pkg::noncomp_op_e'(3'(2 + $urandom_range(2)));
        default: ;
      endcase
      sign_bits = (f == noncomp_pkg::FMT_FP32) ? 32'h8000_0000 : 32'h8000_8000;
      a = rand_word(f);
      b = rand_word(f);
      // Zeros of opposite sign in every half, so -0 meets +0
      if ($urandom_range(7) == 0) begin
        a = a & sign_bits;
        b = a ^ sign_bits;
      end
      send_item(a, b, o, f, v);
    end
    drain();
    tests_run++;
    $display("Test %s finished: %0d items, %0d errors", name, n, errors - errors_before);
  endtask

  // --------------------------------------------------
  // Output monitor sampling before the edge where the item leaves
  // --------------------------------------------------
  always @(negedge clk) begin
    if (arst_n && out_valid && out_ready) begin
      if (exp_res.size() == 0) begin
        errors++;
        $display("Output item at %0t appeared with no item outstanding", $time);
      end else begin
        check_result(result, exp_res.pop_front(), "result_o");
        check_status(status, exp_st.pop_front(), "status_o");
        check_tag(tag_out, exp_tag.pop_front(), "tag_o");
        items_checked++;
      end
    end
  end

  // Watchdog
  initial begin
    #((TOTAL_ITEMS * 20 + 16) * CLK_PERIOD_NS);
    $display("Timeout: the tests did not finish within the allowed time");
    $display("Verification failed");
    $finish;
  end

  initial begin
    void'($urandom(5));
    op_a          = '0;
    op_b          = '0;
    op            = noncomp_pkg::OP_MIN;
    fmt           = noncomp_pkg::FMT_FP32;
    vectorial     = 1'b0;
    simd_mask     = '0;
    tag_in        = '0;
    in_valid      = 1'b0;
    out_ready     = 1'b1;
    stall_en      = 1'b0;
    next_tag      = '0;
    errors        = 0;
    items_checked = 0;
    tests_run     = 0;

    @(posedge arst_n);
    next_cycle();
    check_flag(out_valid, 1'b0, "out_valid_o after reset");
    check_flag(busy, 1'b0, "busy_o after reset");
    check_flag(in_ready, 1'b1, "in_ready_o after reset");
    tests_run++;
    $display("Test reset_state finished: %0d errors", errors);

    run_items("fp32_minmax", ITEMS_PER_TEST, 0);
    run_items("fp16_scalar", ITEMS_PER_TEST, 1);
    run_items("fp16_vector", ITEMS_PER_TEST, 2);
    run_items("sign_inject", ITEMS_PER_TEST, 3);
    stall_en = 1'b1;
    run_items("backpressure", STALL_ITEMS, 4);
    stall_en = 1'b0;

    $display("Summary: %0d tests, %0d items checked, %0d errors",
             tests_run, items_checked, errors);
    if (errors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

// File: all.f
+incdir+tests
hdl/noncomp_pkg.sv
hdl/lane_result_if.sv
hdl/operand_slicer.sv
hdl/noncomp_lane.sv
hdl/result_packer.sv
hdl/noncomp_slice.sv
tests/tb_clock_gen.sv
tests/tb_noncomp_slice.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the noncomp_slice testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing -j 0 -f all.f --top-module tb_noncomp_slice -o sim_noncomp

sim_output="$(./obj_dir/sim_noncomp)"
echo "${sim_output}"

if echo "${sim_output}" | grep -qx "Verification passed"; then
  exit 0
else
  exit 1
fi
